// File: source/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import pipePkg::*; (
	input logic clock,
	input logic reset,
	input logic fetched,
	input wordT instruction,
	output regAddrT readAddr1,
	output regAddrT readAddr2,
	output regAddrT readAddr3,
	input wordT readData1,
	input wordT readData2,
	input wordT readData3,
	output decExT decEx
);

	opcodeT opcode;
	regAddrT rd;
	wordT immediate;
	logic useImm;   // Second operand is the immediate
	decExT decNext;

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////

	assign opcode = opcodeT'(instruction[6:0]);
	assign rd = instruction[11:7];              // Also rs3 for stores
	assign readAddr1 = instruction[16:12];
	assign readAddr2 = instruction[21:17];
	assign readAddr3 = instruction[11:7];
	assign immediate = {{17{instruction[31]}}, instruction[31:17]}; // Sign-extend 15 bits

	always_comb begin
		decNext = '0;
		decNext.rs1Value = readData1;
		decNext.rs3Value = readData3;
		decNext.rs1 = readAddr1;
		decNext.rs3 = readAddr3;
		decNext.rd = rd;
		decNext.aluOp = aluOpT'(instruction[25:22]);
		useImm = 1'b1;
		case (opcode)
			opAluReg: begin
				useImm = 1'b0;
				decNext.regWrite = (rd != '0);
			end
			opAddImm: begin
				decNext.aluOp = aluAdd; // Immediate bits overlap the function field
				decNext.regWrite = (rd != '0);
			end
			opLoad: begin
				decNext.memRead = 1'b1;
				decNext.regWrite = (rd != '0);
			end
			opStore: decNext.memWrite = 1'b1;
			default: ; // No-op, all flags clear
		endcase
		decNext.op2Value = useImm ? immediate : readData2;
		decNext.rs2 = useImm ? regAddrT'(0) : readAddr2; // No rs2 forwarding on immediates
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode/execute staging register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (fetched) decEx <= decNext;
		if (reset || !fetched) begin   // Bubble
			decEx.regWrite <= 1'b0;
			decEx.memRead <= 1'b0;
			decEx.memWrite <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage import pipePkg::*; (
	input logic clock,
	input logic reset,
	input decExT decEx,
	input wbT wb,
	output exMemT exMem
);

	wordT aluIn1;
	wordT aluIn2;
	wordT storeData;
	wordT aluResult;
	aluOpT aluOp;
	exMemT exNext;

	// Take the writeback word when it targets this operand
	function automatic wordT forward(wbT bypass, regAddrT idx, wordT value);
		wordT picked;
		picked = value;
		if (bypass.valid && bypass.rd == idx && idx != '0) picked = bypass.data;
		return picked;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Forwarding select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		aluIn1 = forward(wb, decEx.rs1, decEx.rs1Value);
		aluIn2 = forward(wb, decEx.rs2, decEx.op2Value);   // rs2 zero on immediate
		storeData = forward(wb, decEx.rs3, decEx.rs3Value);
	end

	// Address generation always adds
	assign aluOp = (decEx.memRead || decEx.memWrite) ? aluAdd : decEx.aluOp;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = aluIn1 + aluIn2;
			aluSub: aluResult = aluIn1 - aluIn2;
			aluMul: aluResult = aluIn1 * aluIn2;                    // Low word only
			aluSll: aluResult = aluIn1 << aluIn2[4:0];
			aluSrl: aluResult = aluIn1 >> aluIn2[4:0];
			aluSra: aluResult = wordT'($signed(aluIn1) >>> aluIn2[4:0]);
			aluAnd: aluResult = aluIn1 & aluIn2;
			aluOr: aluResult = aluIn1 | aluIn2;
			aluXor: aluResult = aluIn1 ^ aluIn2;
			default: aluResult = aluIn1 + aluIn2;                   // Unknown codes add
		endcase
	end

	always_comb begin
		exNext.result = aluResult;
		exNext.storeData = storeData;
		exNext.rd = decEx.rd;
		exNext.regWrite = decEx.regWrite;
		exNext.memRead = decEx.memRead;
		exNext.memWrite = decEx.memWrite;
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute/memory staging register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		exMem <= exNext;
		if (reset) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/issuePort.sv
`timescale 1ns/10ps
`default_nettype none

module issuePort import pipePkg::*; (
	input logic clock,
	input logic reset,
	input logic req,
	input wordT instr,
	output logic ack,
	output logic fetched,
	output wordT instruction
);

	// Four-phase receive states
	typedef enum logic {
		idle,  // Waiting for req high
		acked  // Ack up, waiting for req low
	} stateT;

	stateT state;

	assign ack = (state == acked);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			fetched <= 1'b0;
		end else begin
			fetched <= 1'b0; // Single-cycle pulse
			case (state)
				idle: begin
					if (req) begin
						state <= acked;
						fetched <= 1'b1;
					end
				end
				acked: begin
					if (!req) state <= idle; // Host done, drop ack
				end
				default: state <= idle;
			endcase
		end
	end

	// Capture register, loaded as ack rises
	always_ff @(posedge clock) begin
		if (state == idle && req) instruction <= instr;
	end

endmodule

`default_nettype wire

// File: source/memoryStage.sv
`timescale 1ns/10ps
`default_nettype none

module memoryStage import pipePkg::*; #(
	parameter int DataBytes = 512
) (
	input logic clock,
	input logic reset,
	input exMemT exMem,
	output wbT wb
);

	localparam int AddrWidth = $clog2(DataBytes);

	logic [7:0] dataMem [DataBytes];   // Byte wide, big-endian words
	logic [AddrWidth-1:0] addr;
	wordT loadData;
	wbT wbNext;

	assign addr = exMem.result[AddrWidth-1:0]; // Low address bits only

	////////////////////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////////////////////

	// Word store, most significant byte at the lowest address
	always_ff @(posedge clock) begin
		if (exMem.memWrite) begin
			dataMem[addr] <= exMem.storeData[31:24];
			dataMem[addr + 1'b1] <= exMem.storeData[23:16];
			dataMem[addr + 2'd2] <= exMem.storeData[15:8];
			dataMem[addr + 2'd3] <= exMem.storeData[7:0];
		end
	end

	// Load word assembled in the same order
	assign loadData = {dataMem[addr], dataMem[addr + 1'b1],
		dataMem[addr + 2'd2], dataMem[addr + 2'd3]};

	always_comb begin
		wbNext.valid = exMem.regWrite;
		wbNext.rd = exMem.rd;
		wbNext.data = exMem.memRead ? loadData : exMem.result;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory/writeback staging register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		wb <= wbNext;
		if (reset) wb.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: source/pipePkg.sv
`default_nettype none

package pipePkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and base types
	////////////////////////////////////////////////////////////////////////////

	localparam int DataWidth = 32;   // One word
	localparam int RegAddrWidth = 5; // 32 registers

	typedef logic [RegAddrWidth-1:0] regAddrT;
	typedef logic [DataWidth-1:0] wordT;

	// Opcode in bits 6..0, anything else is a no-op
	typedef enum logic [6:0] {
		opAluReg = 7'h33, // rd = rs1 op rs2
		opAddImm = 7'h13, // rd = rs1 + imm
		opLoad = 7'h03,   // rd = mem[rs1 + imm]
		opStore = 7'h23   // mem[rs1 + imm] = reg named by rd field
	} opcodeT;

	// ALU function in bits 25..22
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluMul = 4'd2,
		aluSll = 4'd3,
		aluSrl = 4'd4,
		aluSra = 4'd5,
		aluAnd = 4'd6,
		aluOr = 4'd7,
		aluXor = 4'd8
	} aluOpT;

	////////////////////////////////////////////////////////////////////////////
	// Staging register payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		wordT rs1Value;
		wordT rs3Value;   // Store data
		wordT op2Value;   // rs2 value or immediate
		regAddrT rs1;
		regAddrT rs2;     // Zero when the immediate is selected
		regAddrT rs3;
		regAddrT rd;
		aluOpT aluOp;
		logic regWrite;
		logic memRead;
		logic memWrite;
	} decExT;

	typedef struct packed {
		wordT result;     // ALU result or memory address
		wordT storeData;
		regAddrT rd;
		logic regWrite;
		logic memRead;
		logic memWrite;
	} exMemT;

	// Register file write port, also the pipeline result
	typedef struct packed {
		logic valid;
		regAddrT rd;
		wordT data;
	} wbT;

endpackage

`default_nettype wire

// File: source/pipelineTop.sv
`timescale 1ns/10ps
`default_nettype none

module pipelineTop import pipePkg::*; #(
	parameter int DataBytes = 512   // Data memory size
) (
	input logic clock,
	input logic reset,
	input logic req,
	input wordT instr,
	output logic ack,
	output wbT wb
);

	logic fetched;          // Capture register holds a new instruction
	wordT instruction;
	regAddrT readAddr1;
	regAddrT readAddr2;
	regAddrT readAddr3;
	wordT readData1;
	wordT readData2;
	wordT readData3;
	decExT decEx;
	exMemT exMem;

	// Host handshake in place of fetch
	issuePort issue0 (
		.clock(clock),
		.reset(reset),
		.req(req),
		.instr(instr),
		.ack(ack),
		.fetched(fetched),
		.instruction(instruction)
	);

	decodeStage decode0 (
		.clock(clock),
		.reset(reset),
		.fetched(fetched),
		.instruction(instruction),
		.readAddr1(readAddr1),
		.readAddr2(readAddr2),
		.readAddr3(readAddr3),
		.readData1(readData1),
		.readData2(readData2),
		.readData3(readData3),
		.decEx(decEx)
	);

	registerFile regFile0 (
		.clock(clock),
		.reset(reset),
		.readAddr1(readAddr1),
		.readAddr2(readAddr2),
		.readAddr3(readAddr3),
		.readData1(readData1),
		.readData2(readData2),
		.readData3(readData3),
		.wb(wb)
	);

	executeStage execute0 (
		.clock(clock),
		.reset(reset),
		.decEx(decEx),
		.wb(wb),        // Forwarding source
		.exMem(exMem)
	);

	memoryStage #(
		.DataBytes(DataBytes)
	) memory0 (
		.clock(clock),
		.reset(reset),
		.exMem(exMem),
		.wb(wb)
	);

endmodule

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile import pipePkg::*; (
	input logic clock,
	input logic reset,
	input regAddrT readAddr1,
	input regAddrT readAddr2,
	input regAddrT readAddr3,
	output wordT readData1,
	output wordT readData2,
	output wordT readData3,
	input wbT wb
);

	wordT regs [32];

	// Zero register, then write-through of the word being written this cycle
	function automatic wordT readPort(wbT bypass, regAddrT addr, wordT stored);
		wordT value;
		if (addr == '0) value = '0;
		else if (bypass.valid && bypass.rd == addr) value = bypass.data;
		else value = stored;
		return value;
	endfunction

	always_comb begin
		readData1 = readPort(wb, readAddr1, regs[readAddr1]);
		readData2 = readPort(wb, readAddr2, regs[readAddr2]);
		readData3 = readPort(wb, readAddr3, regs[readAddr3]);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data; // Index 0 never written
		end
	end

endmodule

`default_nettype wire

// File: sources.f
source/pipePkg.sv
source/issuePort.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/pipelineTop.sv
tb/clockGen.sv
tb/pipelineTop_props.sv
tb/pipelineTb.sv

// File: tb/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	// Reset held for four rising edges, released just after the fourth
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb/pipelineTb.sv
`timescale 1ns/10ps
`default_nettype none

module pipelineTb import pipePkg::*; ();

	// One table row: opcode, function or immediate, indices
	typedef struct packed {
		logic [6:0] op;
		logic [14:0] funcImm;  // Function code in bits 3..0 for register ALU
		regAddrT rd;
		regAddrT rs1;
		regAddrT rs2;
		logic randImm;         // Immediate taken from the generator
	} entryT;

	typedef struct packed {
		regAddrT rd;
		wordT data;
		logic [31:0] due;      // Cycle the item must show on wb
	} expItemT;

	logic clock;
	logic reset;
	logic req;
	logic ack;
	wordT instr;
	wbT wb;

	entryT entries[$];
	expItemT pending[$];       // Expected wb items, oldest first
	wordT regModel [32];
	logic [7:0] memModel [512];
	logic [31:0] rngState = 32'd34093;
	int cycleCount = 0;
	int errorCount = 0;

	clockGen clockGen0 (.clock(clock), .reset(reset));

	pipelineTop #(
		.DataBytes(512)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.req(req),
		.instr(instr),
		.ack(ack),
		.wb(wb)
	);

	always @(posedge clock) cycleCount <= cycleCount + 1;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stopRun();
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			errorCount++;
			$display("error: %s is %h, expected %h", name, got, want);
			stopRun();
		end
	endtask

	function automatic wordT xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic wordT signExtend(logic [14:0] imm);
		return {{17{imm[14]}}, imm};
	endfunction

	// Nine ALU functions, any other code adds
	function automatic wordT aluModel(logic [3:0] func, wordT a, wordT b);
		case (func)
			4'd1: return a - b;
			4'd2: return a * b;          // Low 32 bits of the product
			4'd3: return a << b[4:0];
			4'd4: return a >> b[4:0];
			4'd5: return $signed(a) >>> b[4:0];
			4'd6: return a & b;
			4'd7: return a | b;
			4'd8: return a ^ b;
			default: return a + b;
		endcase
	endfunction

	function automatic wordT encode(entryT e);
		wordT word;
		word = '0;
		word[6:0] = e.op;
		word[11:7] = e.rd;
		word[16:12] = e.rs1;
		if (e.op == opAluReg) begin
			word[21:17] = e.rs2;
			word[25:22] = e.funcImm[3:0];
		end else begin
			word[31:17] = e.funcImm;
		end
		return word;
	endfunction

	task automatic addEntry(input logic [6:0] op, input logic [14:0] funcImm,
		input regAddrT rd, input regAddrT rs1, input regAddrT rs2, input logic randImm);
		entryT e;
		e = {op, funcImm, rd, rs1, rs2, randImm};
		entries.push_back(e);
	endtask

	// Reference model, one instruction in issue order
	task automatic modelEntry(input entryT e, output logic writes, output wordT data);
		wordT a;
		logic [8:0] byteAddr;       // Low address bits of a 512 byte memory
		a = regModel[e.rs1];
		byteAddr = 9'(a + signExtend(e.funcImm));
		writes = 1'b0;
		data = '0;
		case (e.op)
			opAluReg: {writes, data} = {1'b1, aluModel(e.funcImm[3:0], a, regModel[e.rs2])};
			opAddImm: {writes, data} = {1'b1, a + signExtend(e.funcImm)};
			opLoad: begin
				writes = 1'b1;
				data = {memModel[byteAddr], memModel[byteAddr + 9'd1],
					memModel[byteAddr + 9'd2], memModel[byteAddr + 9'd3]};
			end
			opStore: {memModel[byteAddr], memModel[byteAddr + 9'd1], memModel[byteAddr + 9'd2],
				memModel[byteAddr + 9'd3]} = regModel[e.rd];   // Big-endian
			default: ;
		endcase
		if (e.rd == '0) writes = 1'b0;
		if (writes) regModel[e.rd] = data;
	endtask

	// Four-phase send, entered and left 1 ns after a rising edge
	task automatic issueWord(input wordT word, output int ackCycle);
		int waitCount;
		req = 1'b1;
		instr = word;
		waitCount = 0;
		do begin
			@(posedge clock);
			#1;
			waitCount++;
			if (waitCount > 20) begin
				$display("timeout: ack never rose after req");
				stopRun();
			end
		end while (ack !== 1'b1);
		ackCycle = cycleCount;
		req = 1'b0;
		waitCount = 0;
		do begin
			@(posedge clock);
			#1;
			waitCount++;
			if (waitCount > 20) begin
				$display("timeout: ack never fell after req dropped");
				stopRun();
			end
		end while (ack !== 1'b0);
	endtask

	task automatic runEntry(input entryT e);
		int ackCycle;
		logic writes;
		wordT data;
		expItemT item;
		if (e.randImm) e.funcImm = 15'(xorshift());
		modelEntry(e, writes, data);
		issueWord(encode(e), ackCycle);
		item = {e.rd, data, 32'(ackCycle + 3)}; // Fixed three cycle latency
		if (writes) pending.push_back(item);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Writeback monitor
	////////////////////////////////////////////////////////////////////////////

	initial begin
		expItemT item;
		forever begin
			@(posedge clock);
			#1;
			if (reset !== 1'b0) continue;
			if (dut0.props0.failCount != 0) begin
				$display("a handshake or writeback assertion failed");
				stopRun();
			end else if (wb.valid === 1'b1) begin
				if (pending.size() == 0) begin
					$display("writeback item appeared when none was expected");
					stopRun();
				end else begin
					item = pending.pop_front();
					checkValue("wb.rd", 32'(wb.rd), 32'(item.rd));
					checkValue("wb.data", wb.data, item.data);
					checkValue("wb cycle", cycleCount, item.due);
				end
			end else if (pending.size() != 0 && pending[0].due <= cycleCount) begin
				$display("expected writeback item did not appear");
				stopRun();
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int waitCount;
		req = 1'b0;
		instr = '0;
		for (int i = 0; i < 32; i++) regModel[i] = '0;

		for (int r = 1; r < 32; r++) addEntry(opAddImm, 15'd0, r, r, 0, 0); // Reset reads
		addEntry(opAddImm, 0, 1, 0, 0, 1);        // Random operands
		addEntry(opAddImm, 0, 2, 0, 0, 1);
		addEntry(opAddImm, 16, 3, 0, 0, 0);
		addEntry(opAluReg, 3, 4, 1, 3, 0);        // rs2 forwarded
		addEntry(opAluReg, 8, 4, 4, 2, 0);        // rs1 forwarded
		addEntry(opAluReg, 12, 14, 4, 2, 0);      // Unknown function adds
		for (int f = 0; f < 9; f++) addEntry(opAluReg, f, 5 + f, 4, 2, 0);
		addEntry(opStore, 'h40, 13, 0, 0, 0);     // Store data forwarded
		addEntry(opLoad, 'h40, 15, 0, 0, 0);
		addEntry(opAluReg, 0, 16, 15, 15, 0);     // Load feeds both operands
		addEntry(opAddImm, 'h18, 17, 0, 0, 0);
		addEntry(opStore, 4, 16, 17, 0, 0);       // Address base forwarded
		addEntry(opLoad, 4, 18, 17, 0, 0);
		addEntry(opAluReg, 8, 19, 16, 18, 0);
		addEntry(opAddImm, 5, 0, 1, 0, 0);        // Register 0 targets, no wb
		addEntry(opAluReg, 0, 0, 1, 2, 0);
		addEntry(opLoad, 'h40, 0, 0, 0, 0);
		addEntry(7'h7F, 0, 5, 1, 2, 0);           // Unknown opcode
		addEntry(opAluReg, 7, 20, 0, 0, 0);       // Register 0 reads zero

		waitCount = 0;
		do begin
			@(posedge clock);
			#1;
			waitCount++;
			if (waitCount > 50) begin
				$display("timeout: reset never released");
				stopRun();
			end
		end while (reset !== 1'b0);

		repeat (4) begin  // Idle after reset
			@(posedge clock);
			#1;
			checkValue("ack", 32'(ack), 32'd0);
			checkValue("wb.valid", 32'(wb.valid), 32'd0);
		end

		foreach (entries[i]) runEntry(entries[i]);

		waitCount = 0;
		while (pending.size() != 0) begin
			@(posedge clock);
			#1;
			waitCount++;
			if (waitCount > 20) begin
				$display("timeout: writeback items still outstanding");
				stopRun();
			end
		end
		repeat (4) @(posedge clock);  // Room for any stray item
		#1;

		if (errorCount == 0 && dut0.props0.failCount == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stopRun();
		end
	end

endmodule

`default_nettype wire

// File: tb/pipelineTop_props.sv
`timescale 1ns/10ps
`default_nettype none

module pipelineTop_props import pipePkg::*; (
	input logic clock,
	input logic reset,
	input logic req,
	input logic ack,
	input wbT wb
);

	int failCount = 0;   // Failed assertions so far

	// Four-phase receive side
	ackRise: assert property (@(posedge clock) disable iff (reset) $rose(ack) |-> $past(req))
		else begin
			failCount++;
			$error("ack rose while req was low");
		end

	ackFall: assert property (@(posedge clock) disable iff (reset) $fell(ack) |-> !$past(req))
		else begin
			failCount++;
			$error("ack fell while req was high");
		end

	// Register 0 is never a writeback target
	noZeroWrite: assert property (@(posedge clock) disable iff (reset) wb.valid |-> wb.rd != '0)
		else begin
			failCount++;
			$error("writeback valid with rd zero");
		end

endmodule

bind pipelineTop pipelineTop_props props0 (
	.clock(clock),
	.reset(reset),
	.req(req),
	.ack(ack),
	.wb(wb)
);

`default_nettype wire
